/* hdl/cpu_pkg.sv */
package cpu_pkg;

    localparam int DATA_W   = 8;
    localparam int ADDR_W   = 16;
    localparam int STAGE_W  = 4;
    localparam int SEL_W    = 5;
    localparam int ALU_OP_W = 5;

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [7:0]          opcode_t;
    typedef logic [STAGE_W-1:0]  stage_t;
    typedef logic [SEL_W-1:0]    reg_sel_t;
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    // Control word single-bit signals
    localparam int CW_HLT         = 0;
    localparam int CW_IR_WE       = 1;
    localparam int CW_MAR_WE      = 2;
    localparam int CW_MEM_WE      = 3;
    localparam int CW_MEM_OE      = 4;
    localparam int CW_REG_WE      = 5;
    localparam int CW_REG_OE      = 6;
    localparam int CW_REG_INC     = 7;
    localparam int CW_ALU_OE      = 8;
    localparam int CW_ALU_EXEC    = 9;
    localparam int CW_ACC_WE      = 10;
    localparam int CW_TMP_WE      = 11;
    localparam int CW_ACT_STORE   = 12;
    localparam int CW_ACT_RESTORE = 13;
    localparam int CW_DISPLAY     = 14;

    // Field bases, each field SEL_W or ALU_OP_W bits wide
    localparam int CW_RD_SEL = 15;
    localparam int CW_WR_SEL = CW_RD_SEL + SEL_W;
    localparam int CW_ALU_OP = CW_WR_SEL + SEL_W;
    localparam int CW_W      = CW_ALU_OP + ALU_OP_W;

    typedef logic [CW_W-1:0] ctrl_word_t;

    // Register select, bit 4 marks a pair and bit 3 the program counter
    localparam int SEL_PAIR = 4;
    localparam int SEL_PC   = 3;

    localparam reg_sel_t REG_B  = 5'b00000;
    localparam reg_sel_t REG_C  = 5'b00001;
    localparam reg_sel_t REG_D  = 5'b00010;
    localparam reg_sel_t REG_E  = 5'b00011;
    localparam reg_sel_t REG_H  = 5'b00100;
    localparam reg_sel_t REG_L  = 5'b00101;
    localparam reg_sel_t REG_W  = 5'b00110;
    localparam reg_sel_t REG_Z  = 5'b00111;
    localparam reg_sel_t REG_PC = 5'b11000;
    localparam reg_sel_t REG_HL = 5'b10100;
    localparam reg_sel_t REG_WZ = 5'b10110;

    // ALU operations, low three bits follow opcode bits 5..3
    localparam alu_op_t ALU_ADD = 5'b00000;
    localparam alu_op_t ALU_ADC = 5'b00001;
    localparam alu_op_t ALU_SUB = 5'b00010;
    localparam alu_op_t ALU_SBB = 5'b00011;
    localparam alu_op_t ALU_ANA = 5'b00100;
    localparam alu_op_t ALU_XRA = 5'b00101;
    localparam alu_op_t ALU_ORA = 5'b00110;
    localparam alu_op_t ALU_CMP = 5'b00111;
    localparam alu_op_t ALU_INR = 5'b10000;
    localparam alu_op_t ALU_DCR = 5'b10001;

    typedef enum logic {
        SEQ_RUN,
        SEQ_HALT
    } seq_state_t;

endpackage

/* hdl/micro_sequencer.sv */
`timescale 1ns/1ps

module micro_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::addr_t      bus,
    input  logic                mem_ready,
    output cpu_pkg::ctrl_word_t ctrl,
    output logic                halted
);
    import cpu_pkg::*;

    opcode_t    ir;
    stage_t     stage;
    seq_state_t state;
    ctrl_word_t cw;
    logic       last;
    logic       hold;
    logic       step;

    function automatic ctrl_word_t bit_at(int pos);
        return ctrl_word_t'(1) << pos;
    endfunction

    function automatic ctrl_word_t sel_read(reg_sel_t sel);
        ctrl_word_t c;
        c = bit_at(CW_REG_OE);
        c[CW_RD_SEL +: SEL_W] = sel;
        return c;
    endfunction

    // Write select together with the enable that acts on it (load or increment)
    function automatic ctrl_word_t sel_write(reg_sel_t sel, int en);
        ctrl_word_t c;
        c = bit_at(en);
        c[CW_WR_SEL +: SEL_W] = sel;
        return c;
    endfunction

    function automatic ctrl_word_t alu_exec(alu_op_t op);
        ctrl_word_t c;
        c = bit_at(CW_ALU_EXEC);
        c[CW_ALU_OP +: ALU_OP_W] = op;
        return c;
    endfunction

    // Operand 7 is the accumulator, which lives in the ALU
    function automatic ctrl_word_t src(logic [2:0] r);
        return (r == 3'd7) ? bit_at(CW_ALU_OE) : sel_read({2'b00, r});
    endfunction

    function automatic ctrl_word_t dst(logic [2:0] r);
        return (r == 3'd7) ? bit_at(CW_ACC_WE) : sel_write({2'b00, r}, CW_REG_WE);
    endfunction

    // MAR takes the old PC while PC steps past the operand byte
    function automatic ctrl_word_t operand_addr();
        return sel_read(REG_PC) | bit_at(CW_MAR_WE) | sel_write(REG_PC, CW_REG_INC);
    endfunction

    always_comb
    begin
        cw = '0;
        last = 1'b0;
        case (stage)
            4'd0: cw = sel_read(REG_PC) | bit_at(CW_MAR_WE);
            4'd1: cw = bit_at(CW_MEM_OE) | bit_at(CW_IR_WE);
            4'd2: cw = sel_write(REG_PC, CW_REG_INC);
            default:
            begin
                casez (ir)
                    8'o166:
                    begin
                        cw = bit_at(CW_HLT);
                        last = 1'b1;
                    end
                    // OUT a8, port byte is skipped
                    8'o323:
                    begin
                        cw = bit_at(CW_DISPLAY) | sel_write(REG_PC, CW_REG_INC);
                        last = 1'b1;
                    end
                    // MOV M,r
                    8'o16?:
                    begin
                        if (stage == 4'd3)
                            cw = sel_read(REG_HL) | bit_at(CW_MAR_WE);
                        else
                        begin
                            cw = src(ir[2:0]) | bit_at(CW_MEM_WE);
                            last = 1'b1;
                        end
                    end
                    // MOV r,M
                    8'o1?6:
                    begin
                        if (stage == 4'd3)
                            cw = sel_read(REG_HL) | bit_at(CW_MAR_WE);
                        else
                        begin
                            cw = bit_at(CW_MEM_OE) | dst(ir[5:3]);
                            last = 1'b1;
                        end
                    end
                    8'o1??:
                    begin
                        cw = src(ir[2:0]) | dst(ir[5:3]);
                        last = 1'b1;
                    end
                    // MVI r,d8
                    8'o0?6:
                    begin
                        if (stage == 4'd3)
                            cw = operand_addr();
                        else
                        begin
                            cw = bit_at(CW_MEM_OE) | dst(ir[5:3]);
                            last = 1'b1;
                        end
                    end
                    // INR / DCR, bit 0 picks DCR
                    8'o0?4, 8'o0?5:
                    begin
                        if (ir[5:3] == 3'd7)
                        begin
                            cw = alu_exec({4'b1000, ir[0]});
                            last = 1'b1;
                        end
                        else
                        begin
                            case (stage)
                                4'd3: cw = sel_read({2'b00, ir[5:3]}) | bit_at(CW_ACT_STORE)
                                           | bit_at(CW_ACC_WE);
                                4'd4: cw = alu_exec({4'b1000, ir[0]});
                                default:
                                begin
                                    cw = bit_at(CW_ALU_OE) | bit_at(CW_ACT_RESTORE)
                                         | dst(ir[5:3]);
                                    last = 1'b1;
                                end
                            endcase
                        end
                    end
                    // ALU group on a register
                    8'o2??:
                    begin
                        if (stage == 4'd3)
                            cw = src(ir[2:0]) | bit_at(CW_TMP_WE);
                        else
                        begin
                            cw = alu_exec({2'b00, ir[5:3]});
                            last = 1'b1;
                        end
                    end
                    // ADI .. CPI
                    8'o3?6:
                    begin
                        case (stage)
                            4'd3: cw = operand_addr();
                            4'd4: cw = bit_at(CW_MEM_OE) | bit_at(CW_TMP_WE);
                            default:
                            begin
                                cw = alu_exec({2'b00, ir[5:3]});
                                last = 1'b1;
                            end
                        endcase
                    end
                    // JMP, STA and LDA all gather the address in WZ first
                    8'o303, 8'o062, 8'o072:
                    begin
                        case (stage)
                            4'd3, 4'd5: cw = operand_addr();
                            4'd4: cw = bit_at(CW_MEM_OE) | sel_write(REG_Z, CW_REG_WE);
                            4'd6: cw = bit_at(CW_MEM_OE) | sel_write(REG_W, CW_REG_WE);
                            4'd7:
                            begin
                                if (ir == 8'o303)
                                begin
                                    cw = sel_read(REG_WZ) | sel_write(REG_PC, CW_REG_WE);
                                    last = 1'b1;
                                end
                                else
                                    cw = sel_read(REG_WZ) | bit_at(CW_MAR_WE);
                            end
                            default:
                            begin
                                // LDA has bit 3 set
                                if (ir[3])
                                    cw = bit_at(CW_MEM_OE) | bit_at(CW_ACC_WE);
                                else
                                    cw = bit_at(CW_ALU_OE) | bit_at(CW_MEM_WE);
                                last = 1'b1;
                            end
                        endcase
                    end
                    // NOP and anything unsupported
                    default: last = 1'b1;
                endcase
            end
        endcase
    end

    assign hold = (cw[CW_MEM_OE] | cw[CW_MEM_WE]) & ~mem_ready;
    assign step = (state == SEQ_RUN) & ~hold;
    assign halted = (state == SEQ_HALT);

    always_comb
    begin
        ctrl = cw;
        if (state == SEQ_HALT)
            ctrl = '0;
        else if (hold)
        begin
            // Waiting on ack keeps only the bus source and the memory request
            ctrl = '0;
            ctrl[CW_MEM_OE] = cw[CW_MEM_OE];
            ctrl[CW_MEM_WE] = cw[CW_MEM_WE];
            ctrl[CW_REG_OE] = cw[CW_REG_OE];
            ctrl[CW_ALU_OE] = cw[CW_ALU_OE];
            ctrl[CW_RD_SEL +: SEL_W] = cw[CW_RD_SEL +: SEL_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ir <= '0;
            stage <= '0;
            state <= SEQ_RUN;
        end
        else
        begin
            if (ctrl[CW_IR_WE] && mem_ready)
                ir <= bus[DATA_W-1:0];
            if (step)
            begin
                stage <= last ? stage_t'(0) : stage + stage_t'(1);
                if (cw[CW_HLT])
                    state <= SEQ_HALT;
            end
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter cpu_pkg::addr_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  cpu_pkg::addr_t      bus,
    output cpu_pkg::addr_t      rd_data
);
    import cpu_pkg::*;

    // B C D E H L W Z, pairs are an even index followed by the odd one
    data_t    regs [8];
    addr_t    pc;
    reg_sel_t rd_sel;
    reg_sel_t wr_sel;
    logic [2:0] wr_hi;
    logic [2:0] wr_lo;
    addr_t    pair_inc;

    assign rd_sel = ctrl[CW_RD_SEL +: SEL_W];
    assign wr_sel = ctrl[CW_WR_SEL +: SEL_W];
    assign wr_hi = {wr_sel[2:1], 1'b0};
    assign wr_lo = {wr_sel[2:1], 1'b1};
    assign pair_inc = {regs[wr_hi], regs[wr_lo]} + addr_t'(1);

    always_comb
    begin
        if (rd_sel[SEL_PC])
            rd_data = pc;
        else if (rd_sel[SEL_PAIR])
            rd_data = {regs[{rd_sel[2:1], 1'b0}], regs[{rd_sel[2:1], 1'b1}]};
        else
            rd_data = {{(ADDR_W - DATA_W){1'b0}}, regs[rd_sel[2:0]]};
    end

    always_ff @(posedge clk)
    begin
        if (!wr_sel[SEL_PC])
        begin
            if (ctrl[CW_REG_INC])
                {regs[wr_hi], regs[wr_lo]} <= pair_inc;
            else if (ctrl[CW_REG_WE] && wr_sel[SEL_PAIR])
                {regs[wr_hi], regs[wr_lo]} <= bus;
            else if (ctrl[CW_REG_WE])
                regs[wr_sel[2:0]] <= bus[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (wr_sel[SEL_PC])
        begin
            if (ctrl[CW_REG_INC])
                pc <= pc + addr_t'(1);
            else if (ctrl[CW_REG_WE])
                pc <= bus;
        end
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  cpu_pkg::addr_t      bus,
    output cpu_pkg::data_t      acc,
    output cpu_pkg::data_t      result
);
    import cpu_pkg::*;

    alu_op_t         op;
    data_t           tmp;
    data_t           shadow;
    logic [DATA_W:0] wide;
    logic            carry_next;
    logic            flag_c;

    assign op = ctrl[CW_ALU_OP +: ALU_OP_W];

    always_comb
    begin
        case (op)
            ALU_ADD: wide = {1'b0, acc} + {1'b0, tmp};
            ALU_ADC: wide = {1'b0, acc} + {1'b0, tmp} + {{DATA_W{1'b0}}, flag_c};
            ALU_SUB, ALU_CMP: wide = {1'b0, acc} - {1'b0, tmp};
            ALU_SBB: wide = {1'b0, acc} - {1'b0, tmp} - {{DATA_W{1'b0}}, flag_c};
            ALU_ANA: wide = {1'b0, acc & tmp};
            ALU_XRA: wide = {1'b0, acc ^ tmp};
            ALU_ORA: wide = {1'b0, acc | tmp};
            ALU_INR: wide = {1'b0, acc + data_t'(1)};
            ALU_DCR: wide = {1'b0, acc - data_t'(1)};
            default: wide = {1'b0, acc};
        endcase
        // Bit 8 is carry or borrow, and it is zero for the logic ops
        carry_next = op[4] ? flag_c : wide[DATA_W];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc <= '0;
            flag_c <= 1'b0;
        end
        else if (ctrl[CW_ALU_EXEC])
        begin
            if (op != ALU_CMP)
                acc <= wide[DATA_W-1:0];
            flag_c <= carry_next;
        end
        else if (ctrl[CW_ACT_RESTORE])
            acc <= shadow;
        else if (ctrl[CW_ACC_WE])
            acc <= bus[DATA_W-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (ctrl[CW_TMP_WE])
            tmp <= bus[DATA_W-1:0];
        // Old A is parked here while INR/DCR borrows the accumulator
        if (ctrl[CW_ACT_STORE])
            shadow <= acc;
        if (ctrl[CW_ALU_EXEC])
            result <= wide[DATA_W-1:0];
    end

endmodule

/* hdl/bus_unit.sv */
`timescale 1ns/1ps

module bus_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  cpu_pkg::addr_t      rd_data,
    input  cpu_pkg::data_t      acc,
    input  cpu_pkg::data_t      result,
    output cpu_pkg::addr_t      bus,
    output logic                mem_ready,
    output cpu_pkg::addr_t      wb_adr,
    output cpu_pkg::data_t      wb_dat_w,
    input  cpu_pkg::data_t      wb_dat_r,
    output logic                wb_we,
    output logic                wb_cyc,
    output logic                wb_stb,
    input  logic                wb_ack,
    output cpu_pkg::data_t      out_data,
    output logic                out_valid
);
    import cpu_pkg::*;

    localparam int PAD_W = ADDR_W - DATA_W;

    addr_t mar;
    data_t rd_capture;
    data_t alu_byte;
    logic  start;
    logic  done;

    // One cycle per memory stage, not reopened in the stage's closing cycle
    assign start = (ctrl[CW_MEM_OE] | ctrl[CW_MEM_WE]) & ~wb_cyc & ~done;
    assign mem_ready = done;
    assign wb_adr = mar;

    // New result only while INR/DCR hands back A, else the accumulator
    assign alu_byte = ctrl[CW_ACT_RESTORE] ? result : acc;

    assign bus = ({ADDR_W{ctrl[CW_REG_OE]}} & rd_data)
               | ({ADDR_W{ctrl[CW_ALU_OE]}} & {{PAD_W{1'b0}}, alu_byte})
               | ({ADDR_W{ctrl[CW_MEM_OE]}} & {{PAD_W{1'b0}}, rd_capture});

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
            done <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            done <= wb_cyc & wb_ack;
            if (wb_cyc && wb_ack)
            begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we <= 1'b0;
            end
            else if (start)
            begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we <= ctrl[CW_MEM_WE];
            end
            out_valid <= ctrl[CW_DISPLAY];
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl[CW_MAR_WE])
            mar <= bus;
        if (start)
            wb_dat_w <= bus[DATA_W-1:0];
        if (wb_cyc && wb_ack)
            rd_capture <= wb_dat_r;
        if (ctrl[CW_DISPLAY])
            out_data <= acc;
    end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::addr_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    output cpu_pkg::addr_t wb_adr,
    output cpu_pkg::data_t wb_dat_w,
    input  cpu_pkg::data_t wb_dat_r,
    output logic           wb_we,
    output logic           wb_cyc,
    output logic           wb_stb,
    input  logic           wb_ack,
    output cpu_pkg::data_t out_data,
    output logic           out_valid,
    output logic           halted
);
    import cpu_pkg::*;

    ctrl_word_t ctrl;
    addr_t      bus;
    addr_t      rd_data;
    data_t      acc;
    data_t      result;
    logic       mem_ready;

    micro_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .mem_ready (mem_ready),
        .ctrl      (ctrl),
        .halted    (halted)
    );

    reg_file #(
        .RESET_PC (RESET_PC)
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .bus     (bus),
        .rd_data (rd_data)
    );

    alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .bus    (bus),
        .acc    (acc),
        .result (result)
    );

    bus_unit u_bus (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .rd_data   (rd_data),
        .acc       (acc),
        .result    (result),
        .bus       (bus),
        .mem_ready (mem_ready),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_we     (wb_we),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_ack    (wb_ack),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

endmodule

/* test/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Columns: name, 16 program bytes from address 0 (first byte leftmost),
// last OUT byte, OUT count, memory address and the byte expected there
task automatic build_table();
    add_row("nop_mvi_out", 128'h00_3E_5A_D3_00_3E_A5_D3_01_76_00_00_00_00_00_00,
            8'hA5, 2, 16'h0100, 8'h00);
    // F0+20 carries into the ADC
    add_row("add_adc", 128'h3E_F0_06_20_80_88_D3_00_76_00_00_00_00_00_00_00,
            8'h31, 1, 16'h0100, 8'h00);
    // 10-20 borrows into the SBB
    add_row("sub_sbb", 128'h3E_10_06_20_90_98_D3_00_76_00_00_00_00_00_00_00,
            8'hCF, 1, 16'h0100, 8'h00);
    add_row("logic_ops", 128'h3E_C3_06_FF_0E_40_80_A0_A8_B1_CE_00_D3_00_76_00,
            8'h7D, 1, 16'h0100, 8'h00);
    // CMP keeps A at 05 and its borrow shows up in ACI
    add_row("cmp_keeps_a", 128'h3E_05_06_07_B8_CE_00_FE_06_CE_10_F6_01_D3_00_76,
            8'h17, 1, 16'h0100, 8'h00);
    add_row("imm_group", 128'h3E_80_C6_90_DE_05_D6_0B_E6_7F_EE_0F_D3_00_76_00,
            8'h70, 1, 16'h0100, 8'h00);
    // B wraps both ways while A keeps 33
    add_row("inr_dcr_b", 128'h3E_33_06_FF_04_04_05_05_05_80_D3_00_76_00_00_00,
            8'h31, 1, 16'h0100, 8'h00);
    // A wraps both ways and the carry from ADI survives INR and DCR
    add_row("inr_dcr_a", 128'h3E_FF_C6_01_3D_3C_3C_CE_10_D3_00_76_00_00_00_00,
            8'h12, 1, 16'h0100, 8'h00);
    add_row("mov_chain", 128'h06_5C_48_51_5A_63_6C_7D_D3_00_76_00_00_00_00_00,
            8'h5C, 1, 16'h0100, 8'h00);
    add_row("sta_lda", 128'h3E_C8_32_34_12_3E_00_3A_34_12_D3_00_76_00_00_00,
            8'hC8, 1, 16'h1234, 8'hC8);
    add_row("mov_m", 128'h26_BE_2E_EF_06_6D_70_4E_79_D3_00_76_00_00_00_00,
            8'h6D, 1, 16'hBEEF, 8'h6D);
    // The OUT of 22 at address 5 is jumped over
    add_row("jmp_skip", 128'h3E_11_C3_09_00_3E_22_D3_00_D3_00_76_00_00_00_00,
            8'h11, 1, 16'h0100, 8'h00);
endtask

`endif

/* test/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int PROG_BYTES   = 16;
    // Budget of 11 stages at 5 cycles for each program byte, well above the longest program
    localparam int CYCLE_LIMIT  = PROG_BYTES * 11 * 5 + 50;
    localparam int QUIET_CYCLES = 10;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    addr_t wb_adr;
    data_t wb_dat_w;
    data_t wb_dat_r = '0;
    logic  wb_we;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_ack = 1'b0;
    data_t out_data;
    logic  out_valid;
    logic  halted;

    // Wishbone memory model
    data_t        mem [65536];
    logic [31:0]  lfsr_state = 32'hb5ebadd7;
    logic         in_cycle;
    int           ack_wait;
    int           load_idx;
    logic [127:0] load_code;
    int           cur_row = 0;

    int    out_count;
    data_t last_out;
    int    errors = 0;
    int    timeouts = 0;
    int    rows_run = 0;

    string        prog_name [$];
    logic [127:0] prog_code [$];
    data_t        exp_out   [$];
    int           exp_count [$];
    addr_t        exp_addr  [$];
    data_t        exp_mem   [$];

    cpu_top #(
        .RESET_PC (16'h0000)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_we     (wb_we),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_ack    (wb_ack),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted)
    );

    task automatic add_row(input string name, input logic [127:0] code, input data_t out_byte,
                           input int count, input addr_t addr, input data_t mem_byte);
        prog_name.push_back(name);
        prog_code.push_back(code);
        exp_out.push_back(out_byte);
        exp_count.push_back(count);
        exp_addr.push_back(addr);
        exp_mem.push_back(mem_byte);
    endtask

    `include "tb_programs.svh"

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Two fresh LFSR bits give 1 to 4 cycles
    task automatic draw_ack_delay(output int delay);
        int i;
        delay = 0;
        for (i = 0; i < 2; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            delay = delay * 2 + int'(lfsr_state[0]);
        end
        delay = delay + 1;
    endtask

    task automatic check_data(input string name, input string what, input data_t expected,
                              input data_t actual);
        if (actual !== expected)
        begin
            $display("ERR %s %s expected %02h actual %02h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int expected,
                               input int actual);
        if (actual != expected)
        begin
            $display("ERR %s %s expected %0d actual %0d", name, what, expected, actual);
            errors++;
        end
    endtask

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_ack <= 1'b0;
            in_cycle = 1'b0;
            ack_wait = 0;
            // Program at address 0, everything else cleared
            load_code = prog_code[cur_row];
            for (load_idx = 0; load_idx < 65536; load_idx++)
                mem[load_idx[15:0]] = 8'h00;
            for (load_idx = 0; load_idx < PROG_BYTES; load_idx++)
            begin
                mem[load_idx[15:0]] = load_code[127 -: 8];
                load_code = load_code << 8;
            end
        end
        else if (wb_ack)
        begin
            wb_ack <= 1'b0;
            in_cycle = 1'b0;
        end
        else if (wb_cyc && wb_stb)
        begin
            if (!in_cycle)
            begin
                in_cycle = 1'b1;
                draw_ack_delay(ack_wait);
            end
            ack_wait = ack_wait - 1;
            if (ack_wait == 0)
            begin
                wb_ack <= 1'b1;
                if (wb_we)
                    mem[wb_adr] = wb_dat_w;
                else
                    wb_dat_r <= mem[wb_adr];
            end
        end
    end

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            out_count <= 0;
            last_out <= '0;
        end
        else if (out_valid)
        begin
            out_count <= out_count + 1;
            last_out <= out_data;
        end
    end

    task automatic run_program(input int r);
        int cycles;
        int quiet;
        cur_row = r;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!halted && cycles < CYCLE_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        rows_run++;
        if (!halted)
        begin
            $display("%s did not halt within %0d cycles", prog_name[r], CYCLE_LIMIT);
            timeouts++;
        end
        else
        begin
            check_data(prog_name[r], "last out", exp_out[r], last_out);
            check_count(prog_name[r], "out count", exp_count[r], out_count);
            check_data(prog_name[r], "memory byte", exp_mem[r], mem[exp_addr[r]]);
            // Halted core stays put and leaves the bus idle
            quiet = 0;
            while (quiet < QUIET_CYCLES)
            begin
                @(negedge clk);
                quiet++;
                if (!halted || wb_cyc)
                begin
                    $display("%s left the halt state or started a bus cycle after HLT",
                             prog_name[r]);
                    errors++;
                    quiet = QUIET_CYCLES;
                end
            end
        end
    endtask

    initial
    begin
        int r;
        build_table();
        r = 0;
        while (r < prog_name.size() && timeouts == 0)
        begin
            run_program(r);
            r++;
        end
        $display("programs run %0d of %0d, failed checks %0d, timeouts %0d",
                 rows_run, prog_name.size(), errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* sim.f */
+incdir+test
hdl/cpu_pkg.sv
hdl/micro_sequencer.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/bus_unit.sv
hdl/cpu_top.sv
test/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_cpu -Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
exit 1
